// ==== Makefile ====
# verilator flow for the register-bus spi slave

VERILATOR   ?= verilator
TOP         ?= spi_reg_tb
FILELIST    ?= list.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing
BUILD_FLAGS ?= --binary -j 0
PASS_MSG    ?= TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/spi_reg_check.svh ====
// reference model of the register map, readback, columns and config
// compare tasks for bytes, bits, counts, strobes and column outputs
`ifndef SPI_REG_CHECK_SVH
`define SPI_REG_CHECK_SVH

// group from the upper nibble and sub-register from the low bits
function automatic spi_reg_pkg::reg_op_e expected_op(input logic [7:0] num);
  spi_reg_pkg::reg_op_e res;
  res = spi_reg_pkg::op_none;
  if (num[7:4] == 4'h1)
    res = num[0] ? spi_reg_pkg::op_kbd_start : spi_reg_pkg::op_kbd_data;
  else if (num[7:4] == 4'h2)
    res = num[1] ? (num[0] ? spi_reg_pkg::op_joy : spi_reg_pkg::op_mus_btn)
                 : (num[0] ? spi_reg_pkg::op_mus_y : spi_reg_pkg::op_mus_x);
  else if (num[7:4] == 4'h3)
    res = spi_reg_pkg::op_reset;
  else if (num[7:4] == 4'h4 && num[1:0] == 2'd0)
    res = spi_reg_pkg::op_wait_data;
  else if (num[7:4] == 4'h4 && num[1:0] == 2'd1)
    res = spi_reg_pkg::op_glu_addr;
  else if (num[7:4] == 4'h4 && num[1:0] == 2'd2)
    res = spi_reg_pkg::op_com_addr;
  else if (num[7:4] == 4'h5)
    res = spi_reg_pkg::op_config;
  return res;
endfunction

// byte the host should shift in during the data phase
function automatic logic [7:0] expected_readback(input logic [7:0] num,
                                                 input logic [7:0] ww, input logic [7:0] wa);
  spi_reg_pkg::reg_op_e op;
  op = expected_op(num);
  if (op == spi_reg_pkg::op_wait_data)
    return ww;
  // both address registers show the same wait address
  if (op == spi_reg_pkg::op_glu_addr || op == spi_reg_pkg::op_com_addr)
    return wa;
  return spi_reg_pkg::IDLE_BYTE;
endfunction

// strobe pattern a committed write should raise
function automatic spi_reg_pkg::periph_stb_t expected_stb(input logic [7:0] num);
  spi_reg_pkg::periph_stb_t res;
  spi_reg_pkg::reg_op_e op;
  op = expected_op(num);
  res.mus_x    = (op == spi_reg_pkg::op_mus_x);
  res.mus_y    = (op == spi_reg_pkg::op_mus_y);
  res.mus_btn  = (op == spi_reg_pkg::op_mus_btn);
  res.joy      = (op == spi_reg_pkg::op_joy);
  res.wait_end = (op == spi_reg_pkg::op_wait_data);
  return res;
endfunction

// full column byte with its stream index as selector
function automatic spi_reg_pkg::kbd_out_t expected_col(input int idx, input logic [7:0] b);
  spi_reg_pkg::kbd_out_t res;
  res.col_data = b;
  res.col_sel  = idx[2:0];
  res.stb      = 1'b1;
  return res;
endfunction

// stored config with the one-shot bit read as zero
function automatic logic [7:0] expected_config0(input logic [7:0] b);
  logic [7:0] res;
  res = b;
  res[spi_reg_pkg::CFG_WTP_BIT] = 1'b0;
  return res;
endfunction

function automatic int expected_pulses(input logic [7:0] b);
  return b[spi_reg_pkg::CFG_WTP_BIT] ? 1 : 0;
endfunction

task automatic note_result(input string name, input bit ok, input string got, input string exp);
  check_cnt++;
  if (!ok)
  begin
    err_cnt++;
    $display("FAILED at %0.3f ns: %s = %s, expected %s", $realtime, name, got, exp);
  end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  note_result(name, got === exp, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  note_result(name, got === exp, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic check_count(input string name, input int got, input int exp);
  note_result(name, got == exp, $sformatf("%0d", got), $sformatf("%0d", exp));
endtask

task automatic check_stb(input string name, input spi_reg_pkg::periph_stb_t got,
                         input spi_reg_pkg::periph_stb_t exp);
  note_result(name, got === exp, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic check_kbd(input string name, input spi_reg_pkg::kbd_out_t got,
                         input spi_reg_pkg::kbd_out_t exp);
  note_result(name, got === exp, $sformatf("%h", got), $sformatf("%h", exp));
endtask

`endif

// ==== bench/spi_reg_tb.sv ====
// testbench for the register-bus spi slave
// clock, reset, spi host tasks, strobe monitor, timeout and tests
`timescale 1ns/1ps

module spi_reg_tb;

  // serial clock half period in fclk cycles
  localparam int HALF     = 6;
  localparam int BYTE_CYC = 16 * HALF;
  localparam int RST_CYC  = 10;
  localparam int N_RST    = 2;
  localparam int N_XFER   = 17;
  localparam int N_BYTE   = 20;
  // twice the cycles of all resets, number phases, gaps and data bytes
  localparam int LIMIT    = 2 * (N_RST * RST_CYC + N_XFER * (BYTE_CYC + 5 * HALF) +
                                 N_BYTE * BYTE_CYC);

  logic fclk, arst_n, spics_n, spick, mosi, miso, genrst;
  logic [7:0] status_in, wait_write, wait_addr, mus_data, wait_read, config0;
  spi_reg_pkg::kbd_out_t kbd;
  spi_reg_pkg::periph_stb_t stb;

  int err_cnt = 0, check_cnt = 0, test_cnt = 0, cycle_cnt = 0, wtp_cnt = 0;
  logic [31:0] lcg_state = 32'd3760;
  logic [7:0] tx_data [8];
  logic [7:0] rx_data [8];
  logic [7:0] status_rd;
  logic [7:0] rd_regs [4] = '{8'h40, 8'h41, 8'h42, 8'h10};
  logic [7:0] wr_regs [5] = '{8'h20, 8'h21, 8'h22, 8'h23, 8'h40};
  // monitor records, one entry per cycle a strobe is high
  spi_reg_pkg::periph_stb_t stb_q [$];
  logic [7:0] mus_q [$];
  spi_reg_pkg::kbd_out_t kbd_q [$];

  `include "spi_reg_check.svh"

  spi_reg_top dut (.*);

  initial
  begin
    fclk = 1'b0;
    forever #4 fclk = ~fclk;
  end

  initial
  begin
    while (cycle_cnt < LIMIT)
    begin
      @(posedge fclk);
      cycle_cnt++;
    end
    $display("timeout, tests still running after %0d cycles", cycle_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // falling edge, outputs settled
  always @(negedge fclk)
  begin
    if (arst_n)
    begin
      if (stb != '0)
      begin
        stb_q.push_back(stb);
        mus_q.push_back(mus_data);
      end
      if (kbd.stb)
        kbd_q.push_back(kbd);
      if (config0[spi_reg_pkg::CFG_WTP_BIT])
        wtp_cnt++;
    end
  end

  // inputs change 1 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge fclk);
    #1;
  endtask

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic apply_reset();
    arst_n = 1'b0;
    wait_cycles(RST_CYC);
    arst_n = 1'b1;
    wait_cycles(4);
  endtask

  task automatic clear_monitors();
    stb_q.delete();
    mus_q.delete();
    kbd_q.delete();
    wtp_cnt = 0;
  endtask

  // lsb first, miso taken just before each rising edge
  task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 0; i < 8; i++)
    begin
      spick = 1'b0;
      mosi  = tx[i];
      wait_cycles(HALF);
      rx[i] = miso;
      spick = 1'b1;
      wait_cycles(HALF);
    end
    spick = 1'b0;
  endtask

  // number phase with chip select high, then data phase, commit on release
  task automatic spi_xfer(input logic [7:0] num, input int nbytes);
    int i;
    shift_byte(num, status_rd);
    wait_cycles(HALF);
    spics_n = 1'b0;
    wait_cycles(HALF);
    for (i = 0; i < nbytes; i++)
      shift_byte(tx_data[i], rx_data[i]);
    wait_cycles(HALF);
    spics_n = 1'b1;
    wait_cycles(2 * HALF);
  endtask

  task automatic test_done(input string name, input int start_err);
    test_cnt++;
    if (err_cnt == start_err)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, err_cnt - start_err);
  endtask

  initial
  begin
    int start_err;
    int i;
    spics_n    = 1'b1;
    spick      = 1'b0;
    mosi       = 1'b0;
    status_in  = 8'h00;
    wait_write = 8'h00;
    wait_addr  = 8'h00;
    apply_reset();

    start_err = err_cnt;
    check_stb("stb", stb, '0);
    check_bit("genrst", genrst, 1'b0);
    check_bit("kbd.stb", kbd.stb, 1'b0);
    check_byte("wait_read", wait_read, 8'h00);
    check_byte("config0", config0, 8'h00);
    test_done("reset", start_err);

    start_err  = err_cnt;
    status_in  = next_rand();
    wait_write = next_rand();
    wait_addr  = next_rand();
    // a first commit loads status for the next number phase
    spi_xfer(8'h00, 0);
    for (i = 0; i < 4; i++)
    begin
      tx_data[0] = next_rand();
      spi_xfer(rd_regs[i], 1);
      check_byte("status", status_rd, status_in);
      check_byte($sformatf("readback of %h", rd_regs[i]), rx_data[0],
                 expected_readback(rd_regs[i], wait_write, wait_addr));
    end
    test_done("readback", start_err);

    start_err = err_cnt;
    for (i = 0; i < 5; i++)
    begin
      tx_data[0] = next_rand();
      clear_monitors();
      spi_xfer(wr_regs[i], 1);
      check_count("strobe cycles", stb_q.size(), 1);
      if (stb_q.size() > 0)
      begin
        check_stb("stb", stb_q[0], expected_stb(wr_regs[i]));
        check_byte("mus_data", mus_q[0], tx_data[0]);
      end
    end
    // last write went to the wait register
    check_byte("wait_read", wait_read, tx_data[0]);
    test_done("strobes", start_err);

    start_err  = err_cnt;
    tx_data[0] = 8'h00;
    spi_xfer(8'h11, 1);
    clear_monitors();
    for (i = 0; i < 5; i++)
      tx_data[i] = next_rand();
    spi_xfer(8'h10, 5);
    check_count("column strobes", kbd_q.size(), 5);
    for (i = 0; i < kbd_q.size() && i < 5; i++)
      check_kbd($sformatf("kbd column %0d", i), kbd_q[i], expected_col(i, tx_data[i]));
    test_done("keyboard", start_err);

    start_err = err_cnt;
    for (i = 0; i < 2; i++)
    begin
      // first write with the one-shot bit, second without
      tx_data[0] = (i == 0) ? (next_rand() | 8'h20) : (next_rand() & 8'hDF);
      clear_monitors();
      spi_xfer(8'h50, 1);
      check_byte("config0", config0, expected_config0(tx_data[0]));
      check_count("config0 pulse cycles", wtp_cnt, expected_pulses(tx_data[0]));
    end
    test_done("config", start_err);

    start_err  = err_cnt;
    tx_data[0] = 8'h01;
    spi_xfer(8'h30, 1);
    check_bit("genrst", genrst, tx_data[0][0]);
    tx_data[0] = 8'h00;
    spi_xfer(8'h30, 1);
    check_bit("genrst", genrst, tx_data[0][0]);
    // set again, a reset must clear it
    tx_data[0] = 8'h01;
    spi_xfer(8'h30, 1);
    apply_reset();
    check_bit("genrst", genrst, 1'b0);
    check_stb("stb", stb, '0);
    test_done("genrst", start_err);

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== hw/kbd_stream.sv ====
// keyboard column stream
// bit counter, column selector and latch strobe
`timescale 1ns/1ps

module kbd_stream
(
  input  logic                  fclk,
  input  logic                  arst_n,
  input  spi_reg_pkg::spi_evt_t evt,
  input  logic                  kbd_bit,
  input  logic                  kbd_start,
  input  logic [7:0]            rx_byte,
  output spi_reg_pkg::kbd_out_t kbd
);

  // low three bits count within a column, upper three pick it
  logic [5:0] bit_cnt;

  always_ff @(posedge fclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt <= 6'd0;
    end
    else if (kbd_start)
    begin
      bit_cnt <= 6'd0;
    end
    else if (kbd_bit)
    begin
      bit_cnt <= bit_cnt + 6'd1;
    end
  end

  // rx_byte lags by one cycle, so join the newest bit in front
  assign kbd.col_data = {evt.sdo, rx_byte[7:1]};
  assign kbd.col_sel  = bit_cnt[5:3];

  // eighth bit of the group completes the column
  assign kbd.stb = kbd_bit && (&bit_cnt[2:0]);

endmodule

// ==== hw/spi_ctrl.sv ====
// register number shifter and opcode decode
// commit, keyboard and peripheral strobes
`timescale 1ns/1ps

module spi_ctrl
(
  input  logic                     fclk,
  input  logic                     arst_n,
  input  spi_reg_pkg::spi_evt_t    evt,
  output spi_reg_pkg::reg_op_e     op,
  output logic                     commit,
  output logic                     kbd_bit,
  output logic                     kbd_start,
  output spi_reg_pkg::periph_stb_t stb
);

  // register number, lsb first while chip select is high
  logic [7:0] regnum;

  always_ff @(posedge fclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      regnum <= 8'd0;
    end
    else if (evt.cs_rise)
    begin
      // new number phase starts from zero
      regnum <= 8'd0;
    end
    else if (evt.scs_n && evt.sck_rise)
    begin
      regnum <= {evt.sdo, regnum[7:1]};
    end
  end

  // decode, upper nibble selects the group
  always_comb
  begin
    op = spi_reg_pkg::op_none;
    case (regnum[7:4])
      spi_reg_pkg::REG_KBD:
      begin
        // only bit 0 tells data from start
        op = regnum[0] ? spi_reg_pkg::op_kbd_start : spi_reg_pkg::op_kbd_data;
      end
      spi_reg_pkg::REG_MUS:
      begin
        case (regnum[1:0])
          2'b00:   op = spi_reg_pkg::op_mus_x;
          2'b01:   op = spi_reg_pkg::op_mus_y;
          2'b10:   op = spi_reg_pkg::op_mus_btn;
          default: op = spi_reg_pkg::op_joy;
        endcase
      end
      spi_reg_pkg::REG_RST:
      begin
        op = spi_reg_pkg::op_reset;
      end
      spi_reg_pkg::REG_WAIT:
      begin
        case (regnum[1:0])
          2'b00:   op = spi_reg_pkg::op_wait_data;
          2'b01:   op = spi_reg_pkg::op_glu_addr;
          2'b10:   op = spi_reg_pkg::op_com_addr;
          // 0x43 is unmapped
          default: op = spi_reg_pkg::op_none;
        endcase
      end
      spi_reg_pkg::REG_CFG:
      begin
        op = spi_reg_pkg::op_config;
      end
      default:
      begin
        op = spi_reg_pkg::op_none;
      end
    endcase
  end

  // end of data phase, regnum still holds during this cycle
  assign commit = evt.cs_rise;

  // one keyboard bit per serial clock in a 0x10 data phase
  assign kbd_bit   = !evt.scs_n && evt.sck_rise && (op == spi_reg_pkg::op_kbd_data);
  assign kbd_start = commit && (op == spi_reg_pkg::op_kbd_start);

  // peripheral strobes fire with commit
  assign stb.mus_x    = commit && (op == spi_reg_pkg::op_mus_x);
  assign stb.mus_y    = commit && (op == spi_reg_pkg::op_mus_y);
  assign stb.mus_btn  = commit && (op == spi_reg_pkg::op_mus_btn);
  assign stb.joy      = commit && (op == spi_reg_pkg::op_joy);
  assign stb.wait_end = commit && (op == spi_reg_pkg::op_wait_data);

endmodule

// ==== hw/spi_reg_pkg.sv ====
// shared types and constants for the register-bus SPI slave
// register opcodes, synchronized SPI events, peripheral strobes
// keyboard column output and fixed register map codes
package spi_reg_pkg;

  // register map, upper nibble of the register number
  // 0x10 keyboard data, 0x11 keyboard start
  localparam logic [3:0] REG_KBD = 4'h1;
  // 0x20 mouse x, 0x21 mouse y, 0x22 buttons, 0x23 joystick
  localparam logic [3:0] REG_MUS = 4'h2;
  // 0x3x reset register, low bits ignored
  localparam logic [3:0] REG_RST = 4'h3;
  // 0x40 wait data, 0x41 glu address, 0x42 com address
  localparam logic [3:0] REG_WAIT = 4'h4;
  // 0x5x configuration register, low bits ignored
  localparam logic [3:0] REG_CFG = 4'h5;

  // readback value for registers with nothing to return
  localparam logic [7:0] IDLE_BYTE = 8'hFF;

  // config bit turned into a one-shot pulse on write
  localparam int CFG_WTP_BIT = 5;

  // decoded register number
  typedef enum logic [3:0] {
    op_kbd_data,
    op_kbd_start,
    op_mus_x,
    op_mus_y,
    op_mus_btn,
    op_joy,
    op_reset,
    op_wait_data,
    op_glu_addr,
    op_com_addr,
    op_config,
    op_none
  } reg_op_e;

  // spi pins after synchronization
  typedef struct packed {
    // chip select level, high in number phase
    logic scs_n;
    // synchronized serial data from host
    logic sdo;
    // chip select low to high, end of data phase
    logic cs_rise;
    // chip select high to low, start of data phase
    logic cs_fall;
    // serial clock rising edge
    logic sck_rise;
  } spi_evt_t;

  // one-cycle strobes towards the peripheral logic
  typedef struct packed {
    logic mus_x;
    logic mus_y;
    logic mus_btn;
    logic joy;
    logic wait_end;
  } periph_stb_t;

  // keyboard column stream
  typedef struct packed {
    // column bits as shifted in
    logic [7:0] col_data;
    // column being written
    logic [2:0] col_sel;
    // latch strobe, one per full column byte
    logic       stb;
  } kbd_out_t;

endpackage

// ==== hw/spi_reg_top.sv ====
// top of the register-bus spi slave
// sync, control, tx, rx and keyboard blocks
`timescale 1ns/1ps

module spi_reg_top
(
  input  logic                     fclk,
  input  logic                     arst_n,
  // host spi pins
  input  logic                     spics_n,
  input  logic                     spick,
  input  logic                     mosi,
  output logic                     miso,
  // readback sources
  input  logic [7:0]               status_in,
  input  logic [7:0]               wait_write,
  input  logic [7:0]               wait_addr,
  // towards the computer core
  output spi_reg_pkg::kbd_out_t    kbd,
  output logic [7:0]               mus_data,
  output spi_reg_pkg::periph_stb_t stb,
  output logic [7:0]               wait_read,
  output logic [7:0]               config0,
  output logic                     genrst
);

  spi_reg_pkg::spi_evt_t evt;
  spi_reg_pkg::reg_op_e  op;
  logic                  commit;
  logic                  kbd_bit;
  logic                  kbd_start;
  logic [7:0]            rx_byte;

  spi_sync u_sync (
    .fclk    (fclk),
    .arst_n  (arst_n),
    .spics_n (spics_n),
    .spick   (spick),
    .mosi    (mosi),
    .evt     (evt)
  );

  spi_ctrl u_ctrl (
    .fclk      (fclk),
    .arst_n    (arst_n),
    .evt       (evt),
    .op        (op),
    .commit    (commit),
    .kbd_bit   (kbd_bit),
    .kbd_start (kbd_start),
    .stb       (stb)
  );

  spi_tx_shift u_tx (
    .fclk       (fclk),
    .arst_n     (arst_n),
    .evt        (evt),
    .op         (op),
    .status_in  (status_in),
    .wait_write (wait_write),
    .wait_addr  (wait_addr),
    .miso       (miso)
  );

  spi_rx_regs u_rx (
    .fclk      (fclk),
    .arst_n    (arst_n),
    .evt       (evt),
    .op        (op),
    .commit    (commit),
    .rx_byte   (rx_byte),
    .wait_read (wait_read),
    .config0   (config0),
    .genrst    (genrst)
  );

  kbd_stream u_kbd (
    .fclk      (fclk),
    .arst_n    (arst_n),
    .evt       (evt),
    .kbd_bit   (kbd_bit),
    .kbd_start (kbd_start),
    .rx_byte   (rx_byte),
    .kbd       (kbd)
  );

  // mouse and joystick bytes come straight from the rx shifter
  assign mus_data = rx_byte;

endmodule

// ==== hw/spi_rx_regs.sv ====
// incoming data shifter
// wait, config and reset registers written on commit
`timescale 1ns/1ps

module spi_rx_regs
(
  input  logic                  fclk,
  input  logic                  arst_n,
  input  spi_reg_pkg::spi_evt_t evt,
  input  spi_reg_pkg::reg_op_e  op,
  input  logic                  commit,
  output logic [7:0]            rx_byte,
  output logic [7:0]            wait_read,
  output logic [7:0]            config0,
  output logic                  genrst
);

  logic [7:0] wait_reg;
  logic [7:0] cfg_reg;
  logic       wtp_pulse;

  // data bits enter at the msb, lsb first on the wire
  always_ff @(posedge fclk)
  begin
    if (!evt.scs_n && evt.sck_rise)
    begin
      rx_byte <= {evt.sdo, rx_byte[7:1]};
    end
  end

  always_ff @(posedge fclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_reg <= 8'd0;
      cfg_reg  <= 8'd0;
      genrst   <= 1'b0;
    end
    else if (commit)
    begin
      case (op)
        spi_reg_pkg::op_wait_data: wait_reg <= rx_byte;
        spi_reg_pkg::op_config:    cfg_reg  <= rx_byte;
        // level follows bit 0 of the last write
        spi_reg_pkg::op_reset:     genrst   <= rx_byte[0];
        default:                   ;
      endcase
    end
  end

  assign wait_read = wait_reg;

  // one-shot, only during the commit of a config write
  assign wtp_pulse = commit && (op == spi_reg_pkg::op_config) &&
                     rx_byte[spi_reg_pkg::CFG_WTP_BIT];

  // stored config with the pulse bit substituted
  always_comb
  begin
    config0 = cfg_reg;
    config0[spi_reg_pkg::CFG_WTP_BIT] = wtp_pulse;
  end

endmodule

// ==== hw/spi_sync.sv ====
// two-flop synchronizers for the spi pins
// edge detection on chip select and serial clock
`timescale 1ns/1ps

module spi_sync
(
  input  logic                  fclk,
  input  logic                  arst_n,
  input  logic                  spics_n,
  input  logic                  spick,
  input  logic                  mosi,
  output spi_reg_pkg::spi_evt_t evt
);

  // stage 0 and 1 resync, stage 2 is the edge reference
  logic [2:0] cs_sync;
  logic [2:0] sck_sync;
  logic [1:0] sdo_sync;

  always_ff @(posedge fclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // chip select idles high, so no edge right after reset
      cs_sync  <= 3'b111;
      sck_sync <= 3'b000;
      sdo_sync <= 2'b00;
    end
    else
    begin
      cs_sync  <= {cs_sync[1:0], spics_n};
      sck_sync <= {sck_sync[1:0], spick};
      sdo_sync <= {sdo_sync[0], mosi};
    end
  end

  // levels from stage 1, edges between stage 1 and 2
  assign evt.scs_n    = cs_sync[1];
  assign evt.sdo      = sdo_sync[1];
  assign evt.cs_rise  = cs_sync[1] && !cs_sync[2];
  assign evt.cs_fall  = !cs_sync[1] && cs_sync[2];
  assign evt.sck_rise = sck_sync[1] && !sck_sync[2];

endmodule

// ==== hw/spi_tx_shift.sv ====
// outgoing shifter towards the host
// status in number phase, readback data in data phase
`timescale 1ns/1ps

module spi_tx_shift
(
  input  logic                  fclk,
  input  logic                  arst_n,
  input  spi_reg_pkg::spi_evt_t evt,
  input  spi_reg_pkg::reg_op_e  op,
  input  logic [7:0]            status_in,
  input  logic [7:0]            wait_write,
  input  logic [7:0]            wait_addr,
  output logic                  miso
);

  logic [7:0] rd_byte;
  logic [7:0] shift_out;

  // readback source by opcode
  always_comb
  begin
    case (op)
      spi_reg_pkg::op_wait_data: rd_byte = wait_write;
      spi_reg_pkg::op_glu_addr:  rd_byte = wait_addr;
      spi_reg_pkg::op_com_addr:  rd_byte = wait_addr;
      default:                   rd_byte = spi_reg_pkg::IDLE_BYTE;
    endcase
  end

  always_ff @(posedge fclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      shift_out <= 8'd0;
    end
    else if (evt.cs_rise || evt.cs_fall)
    begin
      // reload on both chip select edges
      shift_out <= evt.scs_n ? status_in : rd_byte;
    end
    else if (evt.sck_rise)
    begin
      // lsb first, zero fill
      shift_out <= {1'b0, shift_out[7:1]};
    end
  end

  assign miso = shift_out[0];

endmodule

// ==== list.f ====
+incdir+bench
hw/spi_reg_pkg.sv
hw/spi_sync.sv
hw/spi_ctrl.sv
hw/spi_tx_shift.sv
hw/spi_rx_regs.sv
hw/kbd_stream.sv
hw/spi_reg_top.sv
bench/spi_reg_tb.sv
